/* src.f */
+incdir+include
hdl/rv_pkg.sv
hdl/rv_host_regs.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_mem_wb.sv
hdl/rv_core_top.sv
testbench/tb_clkgen.sv
testbench/rv_core_chk.sv
testbench/tb_top.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv_pkg.sv
      - hdl/rv_host_regs.sv
      - hdl/rv_fetch.sv
      - hdl/rv_decode.sv
      - hdl/rv_execute.sv
      - hdl/rv_mem_wb.sv
      - hdl/rv_core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_clkgen.sv
      - testbench/rv_core_chk.sv
      - testbench/tb_top.sv

/* testbench/rv_patterns.txt */
// tag 1: instruction word for the next imem address
// tag 2: expected uart byte, in order
100020537
106400093
1ffd00113
1002082b3
102550023
1402082b3
102550023
10ff0c293
102550023
1001122b3
102550023
1001132b3
102550023
140115293
102550023
101c15293
102550023
100209293
102550023
100000297
102550023
103c0f293
102550023
105a00193
100302423
100802203
100120293
102550023
100528333
1005302b3
102550023
100100293
100400393
102550023
100128293
1fe729ce3
1010000ef
107700293
102550023
10000006f
104200293
102550023
100008067
102550023
200000061
200000067
20000009b
200000001
200000000
2000000fe
20000000f
200000090
20000004c
200000024
20000005b
200000011
200000001
200000002
200000003
200000042
200000077

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module tb_top;

    logic                clk;
    logic                reset;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [`RV_XLEN-1:0] wb_adr;
    logic [`RV_XLEN-1:0] wb_dat_w;
    logic [`RV_XLEN-1:0] wb_dat_r;
    logic                wb_ack;
    logic                tx_valid;
    logic [7:0]          tx_data;

    logic [35:0]         pat_mem [0:127];  // tag nibble then data
    logic [31:0]         prog_q [$];
    logic [7:0]          exp_q [$];
    logic [7:0]          rx_q [$];
    logic [15:0]         lfsr;
    int                  value_errors;
    int                  other_errors;
    bit                  aborted;

    tb_clkgen u_clkgen (.o_clk(clk));

    rv_core_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_adr   (wb_adr),
        .i_wb_dat   (wb_dat_w),
        .o_wb_dat   (wb_dat_r),
        .o_wb_ack   (wb_ack),
        .o_tx_valid (tx_valid),
        .o_tx_data  (tx_data)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic idle_gap();
        logic [1:0] gap;
        lfsr   = lfsr_step(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_step(lfsr);
        gap[1] = lfsr[0];
        repeat (gap) @(negedge clk);
    endtask

    task automatic wb_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdat);
        int waited;
        rdat = '0;
        if (aborted)
            return;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack !== 1'b1 && waited < 20);
        if (wb_ack !== 1'b1) begin
            $display("timeout: host access to %h was never acknowledged", adr);
            other_errors++;
            aborted = 1'b1;
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_value("o_wb_ack", 32'd0, {31'd0, wb_ack});  // exactly one ack
    endtask

    // uart bytes as they leave the core
    always @(negedge clk) begin
        if (!reset && tx_valid === 1'b1)
            rx_q.push_back(tx_data);
    end

    initial begin
        logic [31:0] rd;
        int          waited;
        int          count_before;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        lfsr         = 16'd38394;
        value_errors = 0;
        other_errors = 0;
        aborted      = 1'b0;

        for (int i = 0; i < 128; i++)
            pat_mem[i] = '0;
        $readmemh("testbench/rv_patterns.txt", pat_mem);
        for (int i = 0; i < 128; i++) begin
            if (pat_mem[i][35:32] == 4'h1)
                prog_q.push_back(pat_mem[i][31:0]);
            else if (pat_mem[i][35:32] == 4'h2)
                exp_q.push_back(pat_mem[i][7:0]);
        end
        if (prog_q.size() == 0 || exp_q.size() == 0) begin
            $display("pattern file holds no program or no expected bytes");
            other_errors++;
            aborted = 1'b1;
        end

        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("o_wb_ack", 32'd0, {31'd0, wb_ack});
        check_value("o_tx_valid", 32'd0, {31'd0, tx_valid});

        wb_access(1'b0, `RV_HOST_CTRL_ADDR, '0, rd);
        check_value("ctrl after reset", 32'd0, rd);
        idle_gap();
        wb_access(1'b1, `RV_HOST_CTRL_ADDR, 32'd0, rd);
        idle_gap();
        wb_access(1'b0, `RV_HOST_CTRL_ADDR, '0, rd);
        check_value("ctrl after clear", 32'd0, rd);

        foreach (prog_q[k]) begin
            idle_gap();
            wb_access(1'b1, `RV_HOST_IMEM_BASE + k, prog_q[k], rd);
        end
        idle_gap();
        wb_access(1'b1, `RV_HOST_CTRL_ADDR, 32'd1, rd);
        wb_access(1'b0, `RV_HOST_CTRL_ADDR, '0, rd);
        check_value("ctrl after run", 32'd1, rd);

        waited = 0;
        while (!aborted && rx_q.size() < exp_q.size() && waited < 4000) begin
            @(negedge clk);
            waited++;
        end
        if (!aborted && rx_q.size() < exp_q.size()) begin
            $display("timeout: only %0d of %0d uart bytes arrived", rx_q.size(), exp_q.size());
            other_errors++;
            aborted = 1'b1;
        end

        if (!aborted) begin
            repeat (20) @(negedge clk);    // room for a stray byte
            check_value("uart byte count", exp_q.size(), rx_q.size());
            foreach (exp_q[k]) begin
                if (k < rx_q.size())
                    check_value($sformatf("o_tx_data[%0d]", k), exp_q[k], rx_q[k]);
            end
            count_before = rx_q.size();
            wb_access(1'b1, `RV_HOST_CTRL_ADDR, 32'd0, rd);
            repeat (50) @(negedge clk);
            check_value("uart bytes after halt", count_before, rx_q.size());
        end

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rv_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk (
    input wire clk,
    input wire reset,
    input wire i_wb_cyc,
    input wire i_wb_stb,
    input wire i_wb_ack,
    input wire i_tx_valid,
    input wire i_core_hold
);

    // ack only answers a request seen on the edge before
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else $error("wishbone ack without a request");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        i_wb_ack |=> !i_wb_ack)
        else $error("wishbone ack held for two cycles");

    tx_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(i_tx_valid))
        else $error("uart strobe is unknown");

    tx_quiet_on_hold: assert property (@(posedge clk) disable iff (reset)
        i_core_hold |-> !i_tx_valid)
        else $error("uart strobe while core is held");

endmodule

bind rv_core_top rv_core_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_ack    (o_wb_ack),
    .i_tx_valid  (o_tx_valid),
    .i_core_hold (core_hold)
);

`default_nettype wire

/* testbench/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;    // 4 ns period
    end

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 i_wb_cyc,
    input  wire                 i_wb_stb,
    input  wire                 i_wb_we,
    input  wire  [`RV_XLEN-1:0] i_wb_adr,
    input  wire  [`RV_XLEN-1:0] i_wb_dat,
    output logic [`RV_XLEN-1:0] o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_tx_valid,
    output logic [7:0]          o_tx_data
);

    import rv_pkg::*;

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

    logic                core_hold;
    logic                stage_reset;
    logic                imem_we;
    logic [IMEM_AW-1:0]  imem_addr;
    logic [`RV_XLEN-1:0] imem_data;
    logic                stall;
    logic                jump;
    logic [`RV_XLEN-1:0] jump_addr;
    logic                mem_is_load;
    logic                tx_hit;
    logic [7:0]          tx_byte;
    if_de_t              if_de;
    de_ex_t              de_ex;
    ex_mem_t             ex_mem;
    wb_t                 mem_fwd;
    wb_t                 wb;

    assign stage_reset = reset || core_hold;    // core idles while run is clear

    rv_host_regs u_host_regs (
        .clk         (clk),
        .reset       (reset),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_core_hold (core_hold),
        .o_imem_we   (imem_we),
        .o_imem_addr (imem_addr),
        .o_imem_data (imem_data)
    );

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (stage_reset),
        .i_stall     (stall),
        .i_jump      (jump),
        .i_jump_addr (jump_addr),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_if_de     (if_de)
    );

    rv_decode u_decode (
        .clk     (clk),
        .reset   (stage_reset),
        .i_if_de (if_de),
        .i_stall (stall),
        .i_jump  (jump),
        .i_wb    (wb),
        .o_de_ex (de_ex)
    );

    rv_execute u_execute (
        .i_de_ex       (de_ex),
        .i_mem_fwd     (mem_fwd),
        .i_mem_is_load (mem_is_load),
        .i_wb          (wb),
        .o_ex_mem      (ex_mem),
        .o_stall       (stall),
        .o_jump        (jump),
        .o_jump_addr   (jump_addr),
        .o_tx_hit      (tx_hit),
        .o_tx_byte     (tx_byte)
    );

    rv_mem_wb u_mem_wb (
        .clk           (clk),
        .reset         (stage_reset),
        .i_ex_mem      (ex_mem),
        .i_stall       (stall),
        .o_mem_fwd     (mem_fwd),
        .o_mem_is_load (mem_is_load),
        .o_wb          (wb)
    );

    // one-cycle strobe in the cycle after the sb leaves execute
    always_ff @(posedge clk) begin
        if (stage_reset)
            o_tx_valid <= 1'b0;
        else
            o_tx_valid <= tx_hit;
    end

    always_ff @(posedge clk) begin
        if (tx_hit)
            o_tx_data <= tx_byte;
    end

endmodule

`default_nettype wire

/* hdl/rv_mem_wb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_mem_wb (
    input  wire                   clk,
    input  wire                   reset,
    input  wire rv_pkg::ex_mem_t  i_ex_mem,
    input  wire                   i_stall,
    output rv_pkg::wb_t           o_mem_fwd,
    output logic                  o_mem_is_load,
    output rv_pkg::wb_t           o_wb
);

    import rv_pkg::*;

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    ex_mem_t             mem_q;
    wb_t                 wb_q;
    logic                wb_is_load;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] dmem [0:`RV_DMEM_WORDS-1];
    logic [DMEM_AW-1:0]  dmem_idx;

    always_ff @(posedge clk) begin
        if (reset || i_stall)
            mem_q <= '0;    // bubble behind a stalled instruction
        else
            mem_q <= i_ex_mem;
    end

    assign dmem_idx = mem_q.result[DMEM_AW+1:2];   // word addressed

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mem_q.is_store && mem_q.be[i])
                dmem[dmem_idx][8*i +: 8] <= mem_q.store_data[8*i +: 8];
        end
        load_data <= dmem[dmem_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_q       <= '0;
            wb_is_load <= 1'b0;
        end else begin
            wb_q.we    <= mem_q.we;
            wb_q.rd    <= mem_q.rd;
            wb_q.data  <= mem_q.result;
            wb_is_load <= mem_q.is_load;
        end
    end

    assign o_mem_fwd.we   = mem_q.we;
    assign o_mem_fwd.rd   = mem_q.rd;
    assign o_mem_fwd.data = mem_q.result;
    assign o_mem_is_load  = mem_q.is_load;

    always_comb begin
        o_wb = wb_q;
        if (wb_is_load)
            o_wb.data = load_data;
    end

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_execute (
    input  wire rv_pkg::de_ex_t  i_de_ex,
    input  wire rv_pkg::wb_t     i_mem_fwd,
    input  wire                  i_mem_is_load,
    input  wire rv_pkg::wb_t     i_wb,
    output rv_pkg::ex_mem_t      o_ex_mem,
    output logic                 o_stall,
    output logic                 o_jump,
    output logic [`RV_XLEN-1:0]  o_jump_addr,
    output logic                 o_tx_hit,
    output logic [7:0]           o_tx_byte
);

    import rv_pkg::*;

    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] opb;
    logic [`RV_XLEN-1:0] alu_out;
    logic                taken;
    logic                uart_sel;

    // mem stage first since a load there is not ready yet
    function automatic logic [`RV_XLEN-1:0] fwd(input logic [4:0] idx,
                                                input logic [`RV_XLEN-1:0] val);
        if (i_mem_fwd.we && !i_mem_is_load && i_mem_fwd.rd == idx)
            return i_mem_fwd.data;
        if (i_wb.we && i_wb.rd == idx)
            return i_wb.data;
        return val;
    endfunction

    always_comb begin
        a = fwd(i_de_ex.rs1, i_de_ex.rs1_val);
        b = fwd(i_de_ex.rs2, i_de_ex.rs2_val);
    end

    assign opb = i_de_ex.use_imm ? i_de_ex.imm : b;

    // load-use hold for one cycle until the load reaches writeback
    assign o_stall = i_mem_is_load && i_mem_fwd.we &&
                     (i_mem_fwd.rd == i_de_ex.rs1 || i_mem_fwd.rd == i_de_ex.rs2);

    always_comb begin
        case (i_de_ex.alu_op)
            ALU_ADD:   alu_out = a + opb;
            ALU_SUB:   alu_out = a - b;
            ALU_SLL:   alu_out = a << opb[4:0];
            ALU_SLT:   alu_out = `RV_XLEN'($signed(a) < $signed(opb));
            ALU_SLTU:  alu_out = `RV_XLEN'(a < opb);
            ALU_XOR:   alu_out = a ^ opb;
            ALU_SRL:   alu_out = a >> opb[4:0];
            ALU_SRA:   alu_out = $signed(a) >>> opb[4:0];
            ALU_OR:    alu_out = a | opb;
            ALU_AND:   alu_out = a & opb;
            ALU_LUI:   alu_out = i_de_ex.imm;
            ALU_AUIPC: alu_out = i_de_ex.pc + i_de_ex.imm;
            ALU_LINK:  alu_out = i_de_ex.pc_plus4;   // return address
            default:   alu_out = '0;
        endcase
    end

    always_comb begin
        case (i_de_ex.br_op)
            BR_EQ:           taken = (a == b);
            BR_NE:           taken = (a != b);
            BR_LT:           taken = ($signed(a) < $signed(b));
            BR_GE:           taken = ($signed(a) >= $signed(b));
            BR_LTU:          taken = (a < b);
            BR_GEU:          taken = (a >= b);
            BR_JAL, BR_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // no redirect while stalled since the operands are stale
    assign o_jump      = taken && !o_stall;
    assign o_jump_addr = (i_de_ex.br_op == BR_JALR) ?
                         ((a + i_de_ex.imm) & ~`RV_XLEN'(1)) :
                         (i_de_ex.pc + i_de_ex.imm);

    assign uart_sel  = (alu_out == `RV_UART_TX_ADDR);
    assign o_tx_hit  = i_de_ex.is_sb && uart_sel && !o_stall;
    assign o_tx_byte = b[7:0];

    always_comb begin
        o_ex_mem          = '0;
        o_ex_mem.result   = alu_out;
        o_ex_mem.rd       = i_de_ex.rd;
        o_ex_mem.we       = i_de_ex.we;
        o_ex_mem.is_load  = i_de_ex.is_load;
        o_ex_mem.is_store = i_de_ex.is_store && !uart_sel;    // uart is not memory
        if (i_de_ex.is_sb) begin
            o_ex_mem.be         = 4'b0001 << alu_out[1:0];
            o_ex_mem.store_data = `RV_XLEN'(b[7:0]) << {alu_out[1:0], 3'b000};
        end else begin
            o_ex_mem.be         = 4'b1111;
            o_ex_mem.store_data = b;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_decode (
    input  wire                  clk,
    input  wire                  reset,
    input  wire rv_pkg::if_de_t  i_if_de,
    input  wire                  i_stall,
    input  wire                  i_jump,
    input  wire rv_pkg::wb_t     i_wb,
    output rv_pkg::de_ex_t       o_de_ex
);

    import rv_pkg::*;

    logic [`RV_XLEN-1:0] regs [1:31];   // x0 is not stored
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    opcode_e             opcode;
    de_ex_t              d;

    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [4:0] idx);
        if (idx == 5'd0)
            return '0;
        if (i_wb.we && i_wb.rd == idx)
            return i_wb.data;   // same-cycle writeback
        return regs[idx];
    endfunction

    assign instr  = i_if_de.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'h000};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        d          = '0;
        d.rs1      = instr[19:15];
        d.rs2      = instr[24:20];
        d.rd       = instr[11:7];
        d.rs1_val  = rf_read(d.rs1);
        d.rs2_val  = rf_read(d.rs2);
        d.pc       = i_if_de.pc;
        d.pc_plus4 = i_if_de.pc_plus4;
        case (opcode)
            OP_LUI: begin
                d.alu_op = ALU_LUI;
                d.imm    = imm_u;
                d.we     = 1'b1;
            end
            OP_AUIPC: begin
                d.alu_op = ALU_AUIPC;
                d.imm    = imm_u;
                d.we     = 1'b1;
            end
            OP_JAL: begin
                d.alu_op = ALU_LINK;
                d.br_op  = BR_JAL;
                d.imm    = imm_j;
                d.we     = 1'b1;
            end
            OP_JALR: begin
                d.alu_op = ALU_LINK;
                d.br_op  = (funct3 == 3'b000) ? BR_JALR : BR_NONE;
                d.imm    = imm_i;
                d.we     = (funct3 == 3'b000);
            end
            OP_BRANCH: begin
                d.imm = imm_b;
                case (funct3)
                    3'b000:  d.br_op = BR_EQ;
                    3'b001:  d.br_op = BR_NE;
                    3'b100:  d.br_op = BR_LT;
                    3'b101:  d.br_op = BR_GE;
                    3'b110:  d.br_op = BR_LTU;
                    3'b111:  d.br_op = BR_GEU;
                    default: d.br_op = BR_NONE;
                endcase
            end
            OP_LOAD: begin  // lw only
                d.imm     = imm_i;
                d.use_imm = 1'b1;
                d.is_load = (funct3 == 3'b010);
                d.we      = (funct3 == 3'b010);
            end
            OP_STORE: begin // sb and sw
                d.imm      = imm_s;
                d.use_imm  = 1'b1;
                d.is_sb    = (funct3 == 3'b000);
                d.is_store = (funct3 == 3'b000) || (funct3 == 3'b010);
            end
            OP_IMM, OP_REG: begin
                d.imm     = imm_i;
                d.use_imm = (opcode == OP_IMM);
                d.we      = (opcode == OP_IMM) || (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000:  d.alu_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001:  d.alu_op = ALU_SLL;
                    3'b010:  d.alu_op = ALU_SLT;
                    3'b011:  d.alu_op = ALU_SLTU;
                    3'b100:  d.alu_op = ALU_XOR;
                    3'b101:  d.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  d.alu_op = ALU_OR;
                    default: d.alu_op = ALU_AND;
                endcase
            end
            default: ;  // unknown opcode goes down as a bubble
        endcase
        if (d.rd == 5'd0)
            d.we = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (i_wb.we)
            regs[i_wb.rd] <= i_wb.data;
    end

    always_ff @(posedge clk) begin
        if (reset || i_jump) begin
            o_de_ex <= '0;
        end else if (i_stall) begin
            // held operands would miss the result retiring this cycle
            if (i_wb.we && i_wb.rd == o_de_ex.rs1)
                o_de_ex.rs1_val <= i_wb.data;
            if (i_wb.we && i_wb.rd == o_de_ex.rs2)
                o_de_ex.rs2_val <= i_wb.data;
        end else begin
            o_de_ex <= d;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_fetch (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                i_stall,
    input  wire                                i_jump,
    input  wire  [`RV_XLEN-1:0]                i_jump_addr,
    input  wire                                i_imem_we,
    input  wire  [$clog2(`RV_IMEM_WORDS)-1:0]  i_imem_addr,
    input  wire  [`RV_XLEN-1:0]                i_imem_data,
    output rv_pkg::if_de_t                     o_if_de
);

    import rv_pkg::*;

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] imem [0:`RV_IMEM_WORDS-1];

    assign pc_plus4 = pc + `RV_XLEN'(4);

    always_ff @(posedge clk) begin
        if (i_imem_we)
            imem[i_imem_addr] <= i_imem_data;   // host load port
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else if (i_jump)
            pc <= i_jump_addr;
        else if (!i_stall)
            pc <= pc_plus4;
    end

    // synchronous read lands directly in the fetch/decode register
    always_ff @(posedge clk) begin
        if (reset || i_jump) begin
            o_if_de <= '0;  // zero word decodes as a bubble
        end else if (!i_stall) begin
            o_if_de.instr    <= imem[pc[IMEM_AW+1:2]];
            o_if_de.pc       <= pc;
            o_if_de.pc_plus4 <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_host_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_host_regs (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                i_wb_cyc,
    input  wire                                i_wb_stb,
    input  wire                                i_wb_we,
    input  wire  [`RV_XLEN-1:0]                i_wb_adr,
    input  wire  [`RV_XLEN-1:0]                i_wb_dat,
    output logic [`RV_XLEN-1:0]                o_wb_dat,
    output logic                               o_wb_ack,
    output logic                               o_core_hold,
    output logic                               o_imem_we,
    output logic [$clog2(`RV_IMEM_WORDS)-1:0]  o_imem_addr,
    output logic [`RV_XLEN-1:0]                o_imem_data
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

    logic                run;
    logic                req;       // first cycle of a request
    logic                ctrl_sel;
    logic                imem_sel;
    logic [`RV_XLEN-1:0] imem_off;

    assign req      = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign imem_off = i_wb_adr - `RV_HOST_IMEM_BASE;
    assign ctrl_sel = (i_wb_adr == `RV_HOST_CTRL_ADDR);
    assign imem_sel = (imem_off < `RV_IMEM_WORDS);

    always_ff @(posedge clk) begin
        if (reset) begin
            run      <= 1'b0;
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= req;    // single cycle since req drops while ack is high
            if (req && i_wb_we && ctrl_sel)
                run <= i_wb_dat[0];
        end
    end

    always_ff @(posedge clk) begin
        if (req)
            o_wb_dat <= ctrl_sel ? {{(`RV_XLEN-1){1'b0}}, run} : '0;
    end

    assign o_core_hold = !run;

    // imem only writable while the core is halted
    assign o_imem_we   = req && i_wb_we && imem_sel && !run;
    assign o_imem_addr = imem_off[IMEM_AW-1:0];
    assign o_imem_data = i_wb_dat;

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none
`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
        ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC, ALU_LINK
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] instr;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pc_plus4;
    } if_de_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        alu_op_e             alu_op;
        br_op_e              br_op;
        logic                use_imm;
        logic                is_load;
        logic                is_store;
        logic                is_sb;
        logic                we;        // never set for rd == x0
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pc_plus4;
    } de_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] store_data;
        logic [3:0]          be;
        logic                is_load;
        logic                is_store;
        logic                we;
        logic [4:0]          rd;
    } ex_mem_t;

    typedef struct packed {
        logic                we;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* include/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define RV_XLEN 32

// memory depths in words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

// sb to this byte address goes to the uart
`define RV_UART_TX_ADDR 32'h0002_0020

// host map in word addresses
`define RV_HOST_CTRL_ADDR 32'h0000_0000
`define RV_HOST_IMEM_BASE 32'h0000_0100

`endif
